// ==== rtl/mod_pkg.sv ====
// Shared types for the modulation subsystem: bus regions, register map and playback state.
// Referenced with scoped names from every RTL module.
package mod_pkg;

  // Upper address bits of the CPU bus pick the memory region.
  typedef enum logic [1:0] {
    REGION_CONTROLLER = 2'h0,
    REGION_MOD        = 2'h1,
    REGION_NORMAL     = 2'h2  // Accepted on the bus, nothing is stored.
  } bram_select_e;

  typedef enum logic [13:0] {
    ADDR_CTL_FLAG       = 14'h000,
    ADDR_MOD_MEM_PAGE   = 14'h020,
    ADDR_MOD_CYCLE      = 14'h021,
    ADDR_MOD_FREQ_DIV_0 = 14'h022,
    ADDR_MOD_FREQ_DIV_1 = 14'h023
  } ctl_addr_e;

  localparam int CTL_FLAG_SYNC_BIT = 8;

  typedef struct packed {
    logic         valid;
    bram_select_e select;
    logic [13:0]  addr;
    logic [15:0]  data;
  } bus_wr_t;

  typedef struct packed {
    logic        run;
    logic        page;
    logic [15:0] cycle;     // Index of the last sample.
    logic [31:0] freq_div;  // Clock cycles per sample.
  } mod_cfg_t;

  typedef enum logic [1:0] {
    SEQ_IDLE  = 2'd0,
    SEQ_FETCH = 2'd1,
    SEQ_WAIT  = 2'd2
  } seq_state_e;

endpackage

// ==== rtl/cpu_bus_decoder.sv ====
// Front end of the CPU bus. Turns chip select and write strobe into single write
// commands and decodes read requests for the controller region.
`timescale 1ns/10ps
module cpu_bus_decoder (
  input  logic                  CPU_CKIO,
  input  logic                  rst,
  input  logic                  cs_n,
  input  logic                  we_n,
  input  mod_pkg::bram_select_e select,
  input  logic [13:0]           addr,
  input  logic [15:0]           data_in,
  output mod_pkg::bus_wr_t      wr,
  output logic [13:0]           rd_addr,
  output logic                  rd_en
);

  logic wr_strobe;
  logic wr_strobe_q;

  assign wr_strobe = ~cs_n & ~we_n;

  // Remember the strobe so a long write pulse is seen only once.
  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      wr_strobe_q <= 1'b0;
    end else begin
      wr_strobe_q <= wr_strobe;
    end
  end

  always_comb begin
    wr.valid  = wr_strobe & ~wr_strobe_q;  // First cycle of the strobe only.
    wr.select = select;
    wr.addr   = addr;
    wr.data   = data_in;
  end

  // Only the controller region can be read back.
  assign rd_en   = ~cs_n & we_n & (select == mod_pkg::REGION_CONTROLLER);
  assign rd_addr = addr;

  a_select_known: assert property (
    @(posedge CPU_CKIO) disable iff (rst)
    !cs_n |-> !$isunknown(select)
  );

endmodule

// ==== rtl/ctl_regs.sv ====
// Controller register bank. Holds the control flag, memory page, cycle length and
// divider, and answers CPU reads with a registered readback.
`timescale 1ns/10ps
module ctl_regs (
  input  logic              CPU_CKIO,
  input  logic              rst,
  input  mod_pkg::bus_wr_t  wr,
  input  logic              rd_en,
  input  logic [13:0]       rd_addr,
  output logic [15:0]       data_out,
  output mod_pkg::mod_cfg_t cfg
);

  logic [15:0] ctl_flag;
  logic        page;
  logic [15:0] cycle;
  logic [31:0] freq_div;
  logic        ctl_wr;

  assign ctl_wr = wr.valid && (wr.select == mod_pkg::REGION_CONTROLLER);

  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      ctl_flag <= '0;
      page     <= 1'b0;
      cycle    <= '0;
      freq_div <= 32'd2;
    end else if (ctl_wr) begin
      case (wr.addr)
        mod_pkg::ADDR_CTL_FLAG:       ctl_flag <= wr.data;
        mod_pkg::ADDR_MOD_MEM_PAGE:   page <= wr.data[0];
        mod_pkg::ADDR_MOD_CYCLE:      cycle <= wr.data;
        mod_pkg::ADDR_MOD_FREQ_DIV_0: freq_div[15:0] <= wr.data;
        mod_pkg::ADDR_MOD_FREQ_DIV_1: freq_div[31:16] <= wr.data;
        default: ;
      endcase
    end
  end

  // Readback. Addresses outside the map return zero.
  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      data_out <= '0;
    end else if (rd_en) begin
      case (rd_addr)
        mod_pkg::ADDR_CTL_FLAG:       data_out <= ctl_flag;
        mod_pkg::ADDR_MOD_MEM_PAGE:   data_out <= {15'd0, page};
        mod_pkg::ADDR_MOD_CYCLE:      data_out <= cycle;
        mod_pkg::ADDR_MOD_FREQ_DIV_0: data_out <= freq_div[15:0];
        mod_pkg::ADDR_MOD_FREQ_DIV_1: data_out <= freq_div[31:16];
        default:                      data_out <= '0;
      endcase
    end
  end

  always_comb begin
    cfg.run      = ctl_flag[mod_pkg::CTL_FLAG_SYNC_BIT];
    cfg.page     = page;
    cfg.cycle    = cycle;
    cfg.freq_div = freq_div;
  end

  // The playback pipeline needs two cycles per sample.
  a_freq_div_min: assert property (
    @(posedge CPU_CKIO) disable iff (rst)
    cfg.run |-> cfg.freq_div >= 32'd2
  );

endmodule

// ==== rtl/mod_mem.sv ====
// Modulation sample memory. The CPU writes 16-bit words into the selected page,
// playback reads single bytes by sample index with one cycle of latency.
`timescale 1ns/10ps
module mod_mem #(
  parameter int MOD_ADDR_W = 8
) (
  input  logic                CPU_CKIO,
  input  mod_pkg::bus_wr_t    wr,
  input  logic                page,
  input  logic [MOD_ADDR_W:0] rd_idx,
  output logic [7:0]          rd_value
);

  localparam int DEPTH = 2 ** (MOD_ADDR_W + 1);

  logic [15:0]         mem[DEPTH];
  logic [MOD_ADDR_W:0] wr_word;
  logic [MOD_ADDR_W:0] rd_word;
  logic [15:0]         rd_data_q;
  logic                rd_hi_q;

  // The page bit sits on top of the word address for both ports.
  assign wr_word = {page, wr.addr[MOD_ADDR_W-1:0]};
  assign rd_word = {page, rd_idx[MOD_ADDR_W:1]};

  always_ff @(posedge CPU_CKIO) begin
    if (wr.valid && (wr.select == mod_pkg::REGION_MOD)) begin
      mem[wr_word] <= wr.data;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    rd_data_q <= mem[rd_word];
    rd_hi_q   <= rd_idx[0];
  end

  // Even samples live in the low byte.
  assign rd_value = rd_hi_q ? rd_data_q[15:8] : rd_data_q[7:0];

endmodule

// ==== rtl/mod_timer.sv ====
// Sample rate timer. Divides the clock by freq_div and steps the sample index,
// wrapping after the configured cycle length.
`timescale 1ns/10ps
module mod_timer #(
  parameter int MOD_ADDR_W = 8
) (
  input  logic                CPU_CKIO,
  input  logic                rst,
  input  mod_pkg::mod_cfg_t   cfg,
  output logic                tick,
  output logic [MOD_ADDR_W:0] idx
);

  logic [31:0] div_cnt;
  logic        div_end;
  logic [15:0] idx_ext;

  assign div_end = div_cnt >= cfg.freq_div - 32'd1;
  assign idx_ext = 16'(idx);

  always_ff @(posedge CPU_CKIO) begin
    if (rst || !cfg.run) begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end else begin
      div_cnt <= div_end ? 32'd0 : div_cnt + 32'd1;
      tick    <= div_end;  // Lands freq_div cycles after the period starts.
    end
  end

  // idx is the index carried by the current tick and moves on as the tick ends.
  always_ff @(posedge CPU_CKIO) begin
    if (rst || !cfg.run) begin
      idx <= '0;
    end else if (tick) begin
      if (idx_ext >= cfg.cycle) begin
        idx <= '0;
      end else begin
        idx <= idx + 1'b1;
      end
    end
  end

  a_idx_in_cycle: assert property (
    @(posedge CPU_CKIO) disable iff (rst || !cfg.run)
    idx_ext <= cfg.cycle
  );

endmodule

// ==== rtl/mod_seq_fsm.sv ====
// Playback sequencer. Latches the sample index on each tick, fetches the byte from
// the sample memory and presents it with a one-cycle valid pulse.
`timescale 1ns/10ps
module mod_seq_fsm #(
  parameter int MOD_ADDR_W = 8
) (
  input  logic                CPU_CKIO,
  input  logic                rst,
  input  logic                run,
  input  logic                tick,
  input  logic [MOD_ADDR_W:0] idx,
  output logic [MOD_ADDR_W:0] rd_idx,
  input  logic [7:0]          rd_value,
  output logic [7:0]          mod_value,
  output logic [MOD_ADDR_W:0] mod_idx,
  output logic                mod_valid
);

  mod_pkg::seq_state_e state;
  mod_pkg::seq_state_e state_next;
  logic [MOD_ADDR_W:0] idx_q;
  logic                start;

  assign start = run && tick;

  always_comb begin
    state_next = state;
    case (state)
      mod_pkg::SEQ_IDLE:  if (start) state_next = mod_pkg::SEQ_FETCH;
      mod_pkg::SEQ_FETCH: state_next = mod_pkg::SEQ_WAIT;
      mod_pkg::SEQ_WAIT:  state_next = start ? mod_pkg::SEQ_FETCH : mod_pkg::SEQ_IDLE;
      default:            state_next = mod_pkg::SEQ_IDLE;
    endcase
    if (!run) begin
      state_next = mod_pkg::SEQ_IDLE;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      state <= mod_pkg::SEQ_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Index is held from the tick until the sample has been emitted.
  always_ff @(posedge CPU_CKIO) begin
    if (start) begin
      idx_q <= idx;
    end
  end

  assign rd_idx    = idx_q;  // Memory address during SEQ_FETCH.
  assign mod_valid = state == mod_pkg::SEQ_WAIT;
  assign mod_value = rd_value;
  assign mod_idx   = idx_q;

  // The timer period must cover the two-cycle fetch.
  a_no_tick_in_fetch: assert property (
    @(posedge CPU_CKIO) disable iff (rst)
    state == mod_pkg::SEQ_FETCH |-> !tick
  );

endmodule

// ==== rtl/mod_top.sv ====
// Top level of the amplitude modulation block. Connect the CPU bus pins here and
// take samples from mod_value while mod_valid is high.
`timescale 1ns/10ps
module mod_top #(
  parameter int MOD_ADDR_W = 8
) (
  input  logic                  CPU_CKIO,
  input  logic                  rst,
  input  logic                  cs_n,
  input  logic                  we_n,
  input  mod_pkg::bram_select_e select,
  input  logic [13:0]           addr,
  input  logic [15:0]           data_in,
  output logic [15:0]           data_out,
  output logic [7:0]            mod_value,
  output logic [MOD_ADDR_W:0]   mod_idx,
  output logic                  mod_valid
);

  mod_pkg::bus_wr_t    wr;
  mod_pkg::mod_cfg_t   cfg;
  logic [13:0]         rd_addr;
  logic                rd_en;
  logic                tick;
  logic [MOD_ADDR_W:0] idx;
  logic [MOD_ADDR_W:0] rd_idx;
  logic [7:0]          rd_value;

  cpu_bus_decoder u_cpu_bus_decoder (
    .CPU_CKIO (CPU_CKIO),
    .rst      (rst),
    .cs_n     (cs_n),
    .we_n     (we_n),
    .select   (select),
    .addr     (addr),
    .data_in  (data_in),
    .wr       (wr),
    .rd_addr  (rd_addr),
    .rd_en    (rd_en)
  );

  ctl_regs u_ctl_regs (
    .CPU_CKIO (CPU_CKIO),
    .rst      (rst),
    .wr       (wr),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .data_out (data_out),
    .cfg      (cfg)
  );

  mod_mem #(
    .MOD_ADDR_W (MOD_ADDR_W)
  ) u_mod_mem (
    .CPU_CKIO (CPU_CKIO),
    .wr       (wr),
    .page     (cfg.page),
    .rd_idx   (rd_idx),
    .rd_value (rd_value)
  );

  mod_timer #(
    .MOD_ADDR_W (MOD_ADDR_W)
  ) u_mod_timer (
    .CPU_CKIO (CPU_CKIO),
    .rst      (rst),
    .cfg      (cfg),
    .tick     (tick),
    .idx      (idx)
  );

  mod_seq_fsm #(
    .MOD_ADDR_W (MOD_ADDR_W)
  ) u_mod_seq_fsm (
    .CPU_CKIO  (CPU_CKIO),
    .rst       (rst),
    .run       (cfg.run),
    .tick      (tick),
    .idx       (idx),
    .rd_idx    (rd_idx),
    .rd_value  (rd_value),
    .mod_value (mod_value),
    .mod_idx   (mod_idx),
    .mod_valid (mod_valid)
  );

endmodule

// ==== test/tb_bus_driver.svh ====
// CPU bus access tasks for the modulation testbench. Included inside tb_mod_top,
// where the bus signals are declared.
`ifndef TB_BUS_DRIVER_SVH
`define TB_BUS_DRIVER_SVH

  // Chip select goes low together with the write strobe, which is held for two cycles.
  task automatic bus_write(input mod_pkg::bram_select_e sel, input logic [13:0] a,
                           input logic [15:0] d);
    @(posedge CPU_CKIO);
    select  <= sel;
    addr    <= a;
    data_in <= d;
    cs_n    <= 1'b0;
    we_n    <= 1'b0;
    repeat (2) @(posedge CPU_CKIO);
    we_n <= 1'b1;
    cs_n <= 1'b1;
  endtask

  task automatic bus_read(input logic [13:0] a, output logic [15:0] d);
    @(posedge CPU_CKIO);
    select <= mod_pkg::REGION_CONTROLLER;
    addr   <= a;
    cs_n   <= 1'b0;
    we_n   <= 1'b1;
    @(posedge CPU_CKIO);
    cs_n <= 1'b1;
    @(posedge CPU_CKIO);
    d = data_out;  // Registered readback has settled one cycle after the strobe.
  endtask

  task automatic ctl_write(input mod_pkg::ctl_addr_e a, input logic [15:0] d);
    bus_write(mod_pkg::REGION_CONTROLLER, a, d);
  endtask

  task automatic set_freq_div(input logic [31:0] fd);
    ctl_write(mod_pkg::ADDR_MOD_FREQ_DIV_0, fd[15:0]);
    ctl_write(mod_pkg::ADDR_MOD_FREQ_DIV_1, fd[31:16]);
  endtask

  task automatic set_run(input logic run);
    logic [15:0] flag;
    flag = '0;
    flag[mod_pkg::CTL_FLAG_SYNC_BIT] = run;
    ctl_write(mod_pkg::ADDR_CTL_FLAG, flag);
  endtask

`endif

// ==== test/tb_mod_top.sv ====
// Directed testbench for the modulation block. Drives the CPU bus and checks register
// readback and the played sample stream against a local copy of the sample memory.
`timescale 1ns/10ps
module tb_mod_top;

  localparam int MOD_ADDR_W   = 8;
  localparam int RESET_CYCLES = 10;
  // Estimated cycles for reset and the five tests in order.
  localparam int TEST_CYCLES    = RESET_CYCLES + 60 + 200 + 150 + 200 + 100;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                  CPU_CKIO = 1'b0;
  logic                  rst;
  logic                  cs_n;
  logic                  we_n;
  mod_pkg::bram_select_e select;
  logic [13:0]           addr;
  logic [15:0]           data_in;
  logic [15:0]           data_out;
  logic [7:0]            mod_value;
  logic [MOD_ADDR_W:0]   mod_idx;
  logic                  mod_valid;
  logic [7:0]            exp_bytes[2][32];  // Bytes written per page, by sample index.
  logic [31:0]           lfsr_state = 32'h182f_4dea;
  int                    cycle_cnt = 0;

  mod_top #(.MOD_ADDR_W(MOD_ADDR_W)) uut (
    .CPU_CKIO (CPU_CKIO),
    .rst      (rst),
    .cs_n     (cs_n),
    .we_n     (we_n),
    .select   (select),
    .addr     (addr),
    .data_in  (data_in),
    .data_out (data_out),
    .mod_value(mod_value),
    .mod_idx  (mod_idx),
    .mod_valid(mod_valid)
  );

  always #20 CPU_CKIO = ~CPU_CKIO;

  always @(posedge CPU_CKIO) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles.", TIMEOUT_CYCLES);
      $display("Verification failed");
      $fatal(1, "Simulation stopped by the cycle limit.");
    end
  end

`include "tb_bus_driver.svh"

  // Taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail: time %0t, %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("Verification failed");
      $fatal(1, "Value mismatch.");
    end
  endtask

  task automatic wait_sample(output logic [MOD_ADDR_W:0] idx, output logic [7:0] value,
                             output int stamp);
    do @(posedge CPU_CKIO); while (mod_valid !== 1'b1);
    idx   = mod_idx;
    value = mod_value;
    stamp = cycle_cnt;
  endtask

  task automatic fill_page(input int pg, input int n_words);
    logic [31:0] r;
    ctl_write(mod_pkg::ADDR_MOD_MEM_PAGE, 16'(pg));
    for (int w = 0; w < n_words; w++) begin
      rand_bits(16, r);
      bus_write(mod_pkg::REGION_MOD, 14'(w), r[15:0]);
      exp_bytes[pg][2*w]   = r[7:0];  // Even sample in the low byte.
      exp_bytes[pg][2*w+1] = r[15:8];
    end
  endtask

  task automatic play_and_check(input int pg, input int cycle_len, input int n_samples);
    logic [MOD_ADDR_W:0] idx;
    logic [7:0]          value;
    int                  stamp;
    for (int i = 0; i < n_samples; i++) begin
      wait_sample(idx, value, stamp);
      check_value("mod_idx", idx, i % (cycle_len + 1));
      check_value("mod_value", value, exp_bytes[pg][i % (cycle_len + 1)]);
    end
  endtask

  task automatic test_register_readback();
    logic [31:0] r_cycle;
    logic [31:0] r_div;
    logic [31:0] r_page;
    logic [31:0] r_flag;
    logic [15:0] rd;
    rand_bits(16, r_cycle);
    rand_bits(32, r_div);
    rand_bits(1, r_page);
    rand_bits(16, r_flag);
    r_flag[mod_pkg::CTL_FLAG_SYNC_BIT] = 1'b0;  // Playback stays off.
    ctl_write(mod_pkg::ADDR_CTL_FLAG, r_flag[15:0]);
    ctl_write(mod_pkg::ADDR_MOD_CYCLE, r_cycle[15:0]);
    set_freq_div(r_div);
    ctl_write(mod_pkg::ADDR_MOD_MEM_PAGE, r_page[15:0]);
    bus_read(mod_pkg::ADDR_CTL_FLAG, rd);
    check_value("data_out ctl_flag", rd, r_flag[15:0]);
    bus_read(mod_pkg::ADDR_MOD_CYCLE, rd);
    check_value("data_out cycle", rd, r_cycle[15:0]);
    bus_read(mod_pkg::ADDR_MOD_FREQ_DIV_0, rd);
    check_value("data_out freq_div_0", rd, r_div[15:0]);
    bus_read(mod_pkg::ADDR_MOD_FREQ_DIV_1, rd);
    check_value("data_out freq_div_1", rd, r_div[31:16]);
    bus_read(mod_pkg::ADDR_MOD_MEM_PAGE, rd);
    check_value("data_out page", rd, r_page[0]);
    bus_read(14'h015, rd);
    check_value("data_out unmapped", rd, 0);
    ctl_write(mod_pkg::ADDR_MOD_MEM_PAGE, 16'd0);
  endtask

  task automatic test_playback_order();
    fill_page(0, 5);
    ctl_write(mod_pkg::ADDR_MOD_CYCLE, 16'd9);
    set_freq_div(5);
    set_run(1'b1);
    play_and_check(0, 9, 25);
    set_run(1'b0);
  endtask

  task automatic check_spacing(input int fd);
    logic [MOD_ADDR_W:0] idx;
    logic [7:0]          value;
    int                  stamp;
    int                  prev;
    set_freq_div(fd);
    set_run(1'b1);
    wait_sample(idx, value, prev);
    repeat (6) begin
      wait_sample(idx, value, stamp);
      check_value("mod_valid spacing", stamp - prev, fd);
      prev = stamp;
    end
    set_run(1'b0);
  endtask

  task automatic test_paging();
    fill_page(1, 3);
    ctl_write(mod_pkg::ADDR_MOD_CYCLE, 16'd5);
    set_freq_div(3);
    set_run(1'b1);
    play_and_check(1, 5, 12);
    set_run(1'b0);
    ctl_write(mod_pkg::ADDR_MOD_MEM_PAGE, 16'd0);
    ctl_write(mod_pkg::ADDR_MOD_CYCLE, 16'd9);
    set_run(1'b1);
    play_and_check(0, 9, 10);  // Page 0 survived the page 1 writes.
    set_run(1'b0);
  endtask

  task automatic test_stop_restart();
    logic [MOD_ADDR_W:0] idx;
    logic [7:0]          value;
    int                  stamp;
    set_freq_div(5);
    set_run(1'b1);
    repeat (3) wait_sample(idx, value, stamp);
    set_run(1'b0);
    repeat (30) begin
      @(posedge CPU_CKIO);
      check_value("mod_valid", mod_valid, 1'b0);
    end
    set_run(1'b1);
    wait_sample(idx, value, stamp);
    check_value("mod_idx", idx, 0);
    check_value("mod_value", value, exp_bytes[0][0]);
    set_run(1'b0);
  endtask

  initial begin
    rst     = 1'b1;
    cs_n    = 1'b1;
    we_n    = 1'b1;
    select  = mod_pkg::REGION_CONTROLLER;
    addr    = '0;
    data_in = '0;
    repeat (RESET_CYCLES) @(posedge CPU_CKIO);
    rst <= 1'b0;
    test_register_readback();
    test_playback_order();
    check_spacing(2);
    check_spacing(7);
    test_paging();
    test_stop_restart();
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== files.f ====
rtl/mod_pkg.sv
rtl/cpu_bus_decoder.sv
rtl/ctl_regs.sv
rtl/mod_mem.sv
rtl/mod_timer.sv
rtl/mod_seq_fsm.sv
rtl/mod_top.sv
+incdir+test
test/tb_mod_top.sv

// ==== Bender.yml ====
package:
  name: mod_subsystem

sources:
  - files:
      - rtl/mod_pkg.sv
      - rtl/cpu_bus_decoder.sv
      - rtl/ctl_regs.sv
      - rtl/mod_mem.sv
      - rtl/mod_timer.sv
      - rtl/mod_seq_fsm.sv
      - rtl/mod_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_mod_top.sv
